/* include/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and program counter width
`define CORE_DATA_W 32
// register number width
`define CORE_REG_AW 5

// primary opcodes
`define OP_SPECIAL 6'h00
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_ADDIU   6'h09
`define OP_ANDI    6'h0c
`define OP_ORI     6'h0d
`define OP_LUI     6'h0f

// function codes under OP_SPECIAL
`define FN_SLL     6'h00
`define FN_ADDU    6'h21
`define FN_SUBU    6'h23
`define FN_AND     6'h24
`define FN_OR      6'h25
`define FN_XOR     6'h26
`define FN_SLT     6'h2a

`endif

/* hdl/core_pkg.sv */
`include "core_defines.svh"

package core_pkg;

    // register-register layout
    typedef struct packed {
        logic [5:0]              opcode;
        logic [`CORE_REG_AW-1:0] rs;
        logic [`CORE_REG_AW-1:0] rt;
        logic [`CORE_REG_AW-1:0] rd;
        logic [4:0]              shamt;
        logic [5:0]              funct;
    } rTypeFields;

    // immediate layout
    typedef struct packed {
        logic [5:0]              opcode;
        logic [`CORE_REG_AW-1:0] rs;
        logic [`CORE_REG_AW-1:0] rt;
        logic [15:0]             imm16;
    } iTypeFields;

    // one instruction word, two views of it
    typedef union packed {
        rTypeFields r;
        iTypeFields i;
    } instrWord;

    // operations the execute ALU knows
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluXor = 3'd4,
        aluSlt = 3'd5,
        aluSll = 3'd6,
        aluLui = 3'd7
    } aluOp;

endpackage

/* hdl/registerFile.sv */
`timescale 1ns/1ns
`include "core_defines.svh"

module registerFile (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`CORE_REG_AW-1:0] rsAddr,
    input  logic [`CORE_REG_AW-1:0] rtAddr,
    output logic [`CORE_DATA_W-1:0] rsData,
    output logic [`CORE_DATA_W-1:0] rtData,
    input  logic                    wrEn,
    input  logic [`CORE_REG_AW-1:0] wrAddr,
    input  logic [`CORE_DATA_W-1:0] wrData
);
    // register zero is not stored
    logic [`CORE_DATA_W-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // write data bypasses the array on an address match
    always_comb begin
        if (rsAddr == '0) begin
            rsData = '0;
        end else if (wrEn && wrAddr == rsAddr) begin
            rsData = wrData;
        end else begin
            rsData = regs[rsAddr];
        end
        if (rtAddr == '0) begin
            rtData = '0;
        end else if (wrEn && wrAddr == rtAddr) begin
            rtData = wrData;
        end else begin
            rtData = regs[rtAddr];
        end
    end

endmodule

/* hdl/decodeStage.sv */
`timescale 1ns/1ns
`include "core_defines.svh"

module decodeStage import core_pkg::*; (
    input  logic [`CORE_DATA_W-1:0] instr,
    input  logic [`CORE_DATA_W-1:0] pc,
    input  logic                    instrValid,
    output logic [`CORE_REG_AW-1:0] rsAddr,
    output logic [`CORE_REG_AW-1:0] rtAddr,
    input  logic [`CORE_DATA_W-1:0] rsData,
    input  logic [`CORE_DATA_W-1:0] rtData,
    output logic                    validD,
    output logic [`CORE_DATA_W-1:0] pcD,
    output logic [`CORE_DATA_W-1:0] rd1D,
    output logic [`CORE_DATA_W-1:0] rd2D,
    output logic [`CORE_REG_AW-1:0] rsD,
    output logic [`CORE_REG_AW-1:0] rtD,
    output logic [`CORE_REG_AW-1:0] destD,
    output logic [`CORE_DATA_W-1:0] immD,
    output logic [4:0]              shamtD,
    output aluOp                    aluOpD,
    output logic                    useImmD,
    output logic                    regWriteD,
    output logic                    isBranchD,
    output logic                    branchNeD,
    output logic                    illegalD
);
    instrWord                word;
    logic [`CORE_DATA_W-1:0] signImm;
    logic [`CORE_DATA_W-1:0] zeroImm;
    logic                    known;
    logic                    writes;
    logic                    rDest;
    logic                    branch;
    logic                    branchNe;

    assign word = instr;

    // register fields from the R view, immediate from the I view
    assign rsAddr  = word.r.rs;
    assign rtAddr  = word.r.rt;
    assign signImm = {{(`CORE_DATA_W-16){word.i.imm16[15]}}, word.i.imm16};
    assign zeroImm = {{(`CORE_DATA_W-16){1'b0}}, word.i.imm16};

    always_comb begin
        known   = 1'b1;
        writes  = 1'b1;
        rDest   = 1'b0;
        branch   = 1'b0;
        branchNe = 1'b0;
        aluOpD  = aluAdd;
        useImmD = 1'b0;
        immD    = signImm;
        case (word.r.opcode)
            `OP_SPECIAL: begin
                rDest = 1'b1;
                case (word.r.funct)
                    `FN_ADDU: aluOpD = aluAdd;
                    `FN_SUBU: aluOpD = aluSub;
                    `FN_AND:  aluOpD = aluAnd;
                    `FN_OR:   aluOpD = aluOr;
                    `FN_XOR:  aluOpD = aluXor;
                    `FN_SLT:  aluOpD = aluSlt;
                    `FN_SLL:  aluOpD = aluSll;
                    default:  known = 1'b0;
                endcase
            end
            `OP_ADDIU: useImmD = 1'b1;
            `OP_ANDI: begin
                useImmD = 1'b1;
                aluOpD  = aluAnd;
                immD    = zeroImm;
            end
            `OP_ORI: begin
                useImmD = 1'b1;
                aluOpD  = aluOr;
                immD    = zeroImm;
            end
            `OP_LUI: begin
                useImmD = 1'b1;
                aluOpD  = aluLui;
                immD    = {word.i.imm16, 16'h0000};
            end
            `OP_BEQ: begin
                branch = 1'b1;
                writes = 1'b0;
            end
            `OP_BNE: begin
                branch   = 1'b1;
                branchNe = 1'b1;
                writes   = 1'b0;
            end
            default: known = 1'b0;
        endcase
    end

    assign validD = instrValid;
    assign pcD    = pc;
    assign rd1D   = rsData;
    assign rd2D   = rtData;
    assign rsD    = word.r.rs;
    assign rtD    = word.r.rt;
    assign shamtD = word.r.shamt;
    assign destD  = rDest ? word.r.rd : word.i.rt;

    // invalid slot leaves every control low
    assign regWriteD = instrValid & known & writes;
    assign isBranchD = instrValid & known & branch;
    assign branchNeD = instrValid & known & branchNe;
    assign illegalD  = instrValid & ~known;

endmodule

/* hdl/idExRegister.sv */
`timescale 1ns/1ns
`include "core_defines.svh"

module idExRegister import core_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    validD,
    input  logic [`CORE_DATA_W-1:0] pcD,
    input  logic [`CORE_DATA_W-1:0] rd1D,
    input  logic [`CORE_DATA_W-1:0] rd2D,
    input  logic [`CORE_REG_AW-1:0] rsD,
    input  logic [`CORE_REG_AW-1:0] rtD,
    input  logic [`CORE_REG_AW-1:0] destD,
    input  logic [`CORE_DATA_W-1:0] immD,
    input  logic [4:0]              shamtD,
    input  aluOp                    aluOpD,
    input  logic                    useImmD,
    input  logic                    regWriteD,
    input  logic                    isBranchD,
    input  logic                    branchNeD,
    input  logic                    illegalD,
    output logic                    validE,
    output logic [`CORE_DATA_W-1:0] pcE,
    output logic [`CORE_DATA_W-1:0] rd1E,
    output logic [`CORE_DATA_W-1:0] rd2E,
    output logic [`CORE_REG_AW-1:0] rsE,
    output logic [`CORE_REG_AW-1:0] rtE,
    output logic [`CORE_REG_AW-1:0] destE,
    output logic [`CORE_DATA_W-1:0] immE,
    output logic [4:0]              shamtE,
    output aluOp                    aluOpE,
    output logic                    useImmE,
    output logic                    regWriteE,
    output logic                    isBranchE,
    output logic                    branchNeE,
    output logic                    illegalE
);

    // flush has priority over stall, so a held slot can still be squashed
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            validE    <= 1'b0;
            pcE       <= '0;
            rd1E      <= '0;
            rd2E      <= '0;
            rsE       <= '0;
            rtE       <= '0;
            destE     <= '0;
            immE      <= '0;
            shamtE    <= '0;
            aluOpE    <= aluAdd;
            useImmE   <= 1'b0;
            regWriteE <= 1'b0;
            isBranchE <= 1'b0;
            branchNeE <= 1'b0;
            illegalE  <= 1'b0;
        end else if (!stall) begin
            validE    <= validD;
            pcE       <= pcD;
            rd1E      <= rd1D;
            rd2E      <= rd2D;
            rsE       <= rsD;
            rtE       <= rtD;
            destE     <= destD;
            immE      <= immD;
            shamtE    <= shamtD;
            aluOpE    <= aluOpD;
            useImmE   <= useImmD;
            regWriteE <= regWriteD;
            isBranchE <= isBranchD;
            branchNeE <= branchNeD;
            illegalE  <= illegalD;
        end
    end

endmodule

/* hdl/executeStage.sv */
`timescale 1ns/1ns
`include "core_defines.svh"

module executeStage import core_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic                    validE,
    input  logic [`CORE_DATA_W-1:0] pcE,
    input  logic [`CORE_DATA_W-1:0] rd1E,
    input  logic [`CORE_DATA_W-1:0] rd2E,
    input  logic [`CORE_REG_AW-1:0] rsE,
    input  logic [`CORE_REG_AW-1:0] rtE,
    input  logic [`CORE_REG_AW-1:0] destE,
    input  logic [`CORE_DATA_W-1:0] immE,
    input  logic [4:0]              shamtE,
    input  aluOp                    aluOpE,
    input  logic                    useImmE,
    input  logic                    regWriteE,
    input  logic                    isBranchE,
    input  logic                    branchNeE,
    input  logic                    illegalE,
    output logic                    flush,
    output logic                    wbValid,
    output logic [`CORE_REG_AW-1:0] wbReg,
    output logic [`CORE_DATA_W-1:0] wbData,
    output logic                    redirectValid,
    output logic [`CORE_DATA_W-1:0] redirectPc,
    output logic                    illegalValid
);
    logic                    wbHeld;
    logic [`CORE_DATA_W-1:0] opA;
    logic [`CORE_DATA_W-1:0] opB;
    logic [`CORE_DATA_W-1:0] srcB;
    logic [`CORE_DATA_W-1:0] aluResult;
    logic [`CORE_DATA_W-1:0] target;
    logic                    taken;
    logic                    writeEn;

    // held write is always the newest value of wbReg
    assign opA  = (wbHeld && wbReg == rsE) ? wbData : rd1E;
    assign opB  = (wbHeld && wbReg == rtE) ? wbData : rd2E;
    assign srcB = useImmE ? immE : opB;

    always_comb begin
        case (aluOpE)
            aluAdd:  aluResult = opA + srcB;
            aluSub:  aluResult = opA - srcB;
            aluAnd:  aluResult = opA & srcB;
            aluOr:   aluResult = opA | srcB;
            aluXor:  aluResult = opA ^ srcB;
            aluSlt:  aluResult = {{(`CORE_DATA_W-1){1'b0}}, $signed(opA) < $signed(srcB)};
            aluSll:  aluResult = opB << shamtE;
            aluLui:  aluResult = srcB;
            default: aluResult = '0;
        endcase
    end

    // branch compare and target
    assign taken  = validE & isBranchE & (branchNeE ? (opA != opB) : (opA == opB));
    assign target = pcE + `CORE_DATA_W'd4 + {immE[`CORE_DATA_W-3:0], 2'b00};
    assign flush  = taken & ~stall;

    // register zero is never written
    assign writeEn = validE & regWriteE & (destE != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            wbValid       <= 1'b0;
            redirectValid <= 1'b0;
            illegalValid  <= 1'b0;
            wbHeld        <= 1'b0;
        end else if (stall) begin
            // pulses drop while the pipe is frozen
            wbValid       <= 1'b0;
            redirectValid <= 1'b0;
            illegalValid  <= 1'b0;
        end else begin
            wbValid       <= writeEn;
            redirectValid <= taken;
            illegalValid  <= validE & illegalE;
            if (writeEn) begin
                wbHeld <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && writeEn) begin
            wbReg  <= destE;
            wbData <= aluResult;
        end
        if (!stall && taken) begin
            redirectPc <= target;
        end
    end

endmodule

/* hdl/coreTop.sv */
`timescale 1ns/1ns
`include "core_defines.svh"

module coreTop import core_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic [`CORE_DATA_W-1:0] instr,
    input  logic [`CORE_DATA_W-1:0] pc,
    input  logic                    instrValid,
    output logic                    wbValid,
    output logic [`CORE_REG_AW-1:0] wbReg,
    output logic [`CORE_DATA_W-1:0] wbData,
    output logic                    redirectValid,
    output logic [`CORE_DATA_W-1:0] redirectPc,
    output logic                    illegalValid
);
    // register file read side
    logic [`CORE_REG_AW-1:0] rsAddr, rtAddr;
    logic [`CORE_DATA_W-1:0] rsData, rtData;

    // decode outputs
    logic                    validD, useImmD, regWriteD, isBranchD, branchNeD, illegalD;
    logic [`CORE_DATA_W-1:0] pcD, rd1D, rd2D, immD;
    logic [`CORE_REG_AW-1:0] rsD, rtD, destD;
    logic [4:0]              shamtD;
    aluOp                    aluOpD;

    // execute inputs
    logic                    validE, useImmE, regWriteE, isBranchE, branchNeE, illegalE;
    logic [`CORE_DATA_W-1:0] pcE, rd1E, rd2E, immE;
    logic [`CORE_REG_AW-1:0] rsE, rtE, destE;
    logic [4:0]              shamtE;
    aluOp                    aluOpE;

    logic flush;

    decodeStage u_decode (
        .instr, .pc, .instrValid, .rsAddr, .rtAddr, .rsData, .rtData,
        .validD, .pcD, .rd1D, .rd2D, .rsD, .rtD, .destD, .immD, .shamtD,
        .aluOpD, .useImmD, .regWriteD, .isBranchD, .branchNeD, .illegalD
    );

    // write port is fed by the writeback pulse
    registerFile u_regs (
        .clk, .reset, .rsAddr, .rtAddr, .rsData, .rtData,
        .wrEn(wbValid), .wrAddr(wbReg), .wrData(wbData)
    );

    idExRegister u_idEx (
        .clk, .reset, .stall, .flush,
        .validD, .pcD, .rd1D, .rd2D, .rsD, .rtD, .destD, .immD, .shamtD,
        .aluOpD, .useImmD, .regWriteD, .isBranchD, .branchNeD, .illegalD,
        .validE, .pcE, .rd1E, .rd2E, .rsE, .rtE, .destE, .immE, .shamtE,
        .aluOpE, .useImmE, .regWriteE, .isBranchE, .branchNeE, .illegalE
    );

    executeStage u_execute (
        .clk, .reset, .stall,
        .validE, .pcE, .rd1E, .rd2E, .rsE, .rtE, .destE, .immE, .shamtE,
        .aluOpE, .useImmE, .regWriteE, .isBranchE, .branchNeE, .illegalE,
        .flush, .wbValid, .wbReg, .wbData, .redirectValid, .redirectPc, .illegalValid
    );

endmodule

/* sim/coreTop_assert.sv */
`timescale 1ns/1ns
`include "core_defines.svh"

module coreTop_assert (
    input logic                    clk,
    input logic                    reset,
    input logic                    stall,
    input logic                    flush,
    input logic                    wbValid,
    input logic [`CORE_REG_AW-1:0] wbReg,
    input logic                    redirectValid,
    input logic                    illegalValid
);

    // pipe comes out of reset quiet
    assert property (@(posedge clk)
        reset |=> !(wbValid || redirectValid || illegalValid || flush))
        else $error("result pulse or flush active right after reset");

    // a frozen edge drops every pulse
    assert property (@(posedge clk) disable iff (reset)
        stall |=> !(wbValid || redirectValid || illegalValid))
        else $error("result pulse in the cycle after a stalled edge");

    assert property (@(posedge clk) disable iff (reset)
        wbValid |-> wbReg != '0)
        else $error("writeback reported for register zero");

    // squash only on an edge that advances
    assert property (@(posedge clk) disable iff (reset)
        flush |-> !stall)
        else $error("flush raised while stall is high");

endmodule

bind coreTop coreTop_assert u_assert (.*);

/* sim/coreTop_tb.sv */
`timescale 1ns/1ns
`include "core_defines.svh"

module coreTop_tb import core_pkg::*; ();

    localparam int numSlots   = 400;
    localparam int cycleLimit = numSlots * 3 + 100;
    // cycles for the last accepted slot to leave the pipe
    localparam int drainLimit = 8;

    localparam logic [1:0] evNone     = 2'd0;
    localparam logic [1:0] evWb       = 2'd1;
    localparam logic [1:0] evRedirect = 2'd2;
    localparam logic [1:0] evIllegal  = 2'd3;

    // one expected result pulse
    typedef struct packed {
        logic [1:0]              kind;
        logic [`CORE_REG_AW-1:0] regNum;
        logic [`CORE_DATA_W-1:0] value;
    } resultEvent;

    logic                    clk;
    logic                    reset;
    logic                    stall;
    logic [`CORE_DATA_W-1:0] instr;
    logic [`CORE_DATA_W-1:0] pc;
    logic                    instrValid;
    logic                    wbValid;
    logic [`CORE_REG_AW-1:0] wbReg;
    logic [`CORE_DATA_W-1:0] wbData;
    logic                    redirectValid;
    logic [`CORE_DATA_W-1:0] redirectPc;
    logic                    illegalValid;

    logic [`CORE_DATA_W-1:0] modelRegs [0:31];
    resultEvent              pendingResults [$];
    logic                    squashNext;
    int                      seed;
    int                      slotCount;
    int                      cycleCount = 0;

    coreTop DUT (
        .clk, .reset, .stall, .instr, .pc, .instrValid,
        .wbValid, .wbReg, .wbData, .redirectValid, .redirectPc, .illegalValid
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expectedValue);
        if (actual !== expectedValue) begin
            $display("mismatch at %0t ns: %s is %h, expected %h",
                     $time, name, actual, expectedValue);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // architectural result of one instruction on operands a and b
    function automatic resultEvent referenceResult(input logic [31:0] word,
                                                   input logic [31:0] slotPc,
                                                   input logic [31:0] a,
                                                   input logic [31:0] b);
        instrWord    w;
        logic [31:0] sext;
        logic [31:0] zext;
        resultEvent  ev;
        w = word;
        sext = {{16{w.i.imm16[15]}}, w.i.imm16};
        zext = {16'h0000, w.i.imm16};
        ev.kind = evWb;
        ev.regNum = w.i.rt;
        ev.value = '0;
        case (w.i.opcode)
            `OP_SPECIAL: begin
                ev.regNum = w.r.rd;
                case (w.r.funct)
                    `FN_ADDU: ev.value = a + b;
                    `FN_SUBU: ev.value = a - b;
                    `FN_AND:  ev.value = a & b;
                    `FN_OR:   ev.value = a | b;
                    `FN_XOR:  ev.value = a ^ b;
                    `FN_SLT:  ev.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `FN_SLL:  ev.value = b << w.r.shamt;
                    default:  ev.kind = evIllegal;
                endcase
            end
            `OP_ADDIU: ev.value = a + sext;
            `OP_ANDI:  ev.value = a & zext;
            `OP_ORI:   ev.value = a | zext;
            `OP_LUI:   ev.value = {w.i.imm16, 16'h0000};
            `OP_BEQ, `OP_BNE: begin
                ev.kind = evNone;
                if ((a == b) == (w.i.opcode == `OP_BEQ)) begin
                    ev.kind = evRedirect;
                    ev.value = slotPc + 32'd4 + {sext[29:0], 2'b00};
                end
            end
            default: ev.kind = evIllegal;
        endcase
        // register zero swallows the write
        if (ev.kind == evWb && ev.regNum == '0) begin
            ev.kind = evNone;
        end
        return ev;
    endfunction

    // slot taken at an unstalled edge; the one after a taken branch is squashed
    task automatic acceptSlot(input logic valid, input logic [31:0] word,
                              input logic [31:0] slotPc);
        instrWord   w;
        resultEvent ev;
        w = word;
        if (squashNext) begin
            squashNext = 1'b0;
        end else if (valid) begin
            ev = referenceResult(word, slotPc, modelRegs[w.r.rs], modelRegs[w.r.rt]);
            if (ev.kind == evWb) begin
                modelRegs[ev.regNum] = ev.value;
            end
            squashNext = (ev.kind == evRedirect);
            if (ev.kind != evNone) begin
                pendingResults.push_back(ev);
            end
        end
    endtask

    // small register range keeps dependencies frequent
    function automatic logic [4:0] randomReg();
        return 5'($unsigned($random(seed)) % 8);
    endfunction

    function automatic logic [31:0] randomInstr();
        instrWord w;
        int       pick;
        pick = $unsigned($random(seed)) % 20;
        w.i.opcode = `OP_ADDIU;
        w.i.rs = randomReg();
        w.i.rt = randomReg();
        w.i.imm16 = 16'($random(seed));
        if (pick < 7) begin
            w.r.opcode = `OP_SPECIAL;
            w.r.rd = randomReg();
            w.r.shamt = 5'd0;
            case (pick)
                0: w.r.funct = `FN_ADDU;
                1: w.r.funct = `FN_SUBU;
                2: w.r.funct = `FN_AND;
                3: w.r.funct = `FN_OR;
                4: w.r.funct = `FN_XOR;
                5: w.r.funct = `FN_SLT;
                default: begin
                    w.r.funct = `FN_SLL;
                    w.r.shamt = 5'($random(seed));
                end
            endcase
        end else begin
            case (pick)
                9, 17:   w.i.opcode = `OP_ANDI;
                10, 18:  w.i.opcode = `OP_ORI;
                11:      w.i.opcode = `OP_LUI;
                12, 13:  w.i.opcode = `OP_BEQ;
                14, 15:  w.i.opcode = `OP_BNE;
                16: begin
                    // equal registers, so this BEQ is always taken
                    w.i.opcode = `OP_BEQ;
                    w.i.rt = w.i.rs;
                end
                19: begin
                    if ($random(seed) & 1) begin
                        w.i.opcode = 6'h23;
                    end else begin
                        w.r.opcode = `OP_SPECIAL;
                        w.r.funct = 6'h08;
                    end
                end
                default: w.i.opcode = `OP_ADDIU;
            endcase
        end
        return w;
    endfunction

    initial begin
        logic [31:0] word;
        logic [31:0] nextPc;
        logic        valid;
        int          drainCycles;
        seed = 59;
        reset = 1'b1;
        stall = 1'b0;
        instr = '0;
        pc = '0;
        instrValid = 1'b0;
        squashNext = 1'b0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        slotCount = 0;
        nextPc = 32'h0040_0000;
        while (slotCount < numSlots) begin
            @(posedge clk);
            if (($unsigned($random(seed)) % 5) == 0) begin
                // slot stays on the inputs while frozen
                stall <= 1'b1;
            end else begin
                word = randomInstr();
                valid = ($unsigned($random(seed)) % 8) != 0;
                stall <= 1'b0;
                instr <= word;
                pc <= nextPc;
                instrValid <= valid;
                acceptSlot(valid, word, nextPc);
                if (valid) begin
                    nextPc = nextPc + 32'd4;
                end
                slotCount++;
            end
        end
        @(posedge clk);
        stall <= 1'b0;
        instrValid <= 1'b0;
        drainCycles = 0;
        while (pendingResults.size() != 0 && drainCycles < drainLimit) begin
            @(posedge clk);
            drainCycles++;
        end
        // pipe depth, catches stray pulses after the last result
        repeat (4) @(posedge clk);
        if (pendingResults.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("%0d expected results never appeared", pendingResults.size());
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    // outputs settle after the rising edge, so sample on the falling one
    always @(negedge clk) begin
        resultEvent ev;
        logic [1:0] seen;
        if (reset === 1'b0 &&
            (wbValid === 1'b1 || redirectValid === 1'b1 || illegalValid === 1'b1)) begin
            if (pendingResults.size() == 0) begin
                $display("unexpected result pulse at %0t ns with nothing outstanding", $time);
                $display("TEST FAILED");
                $fatal(1);
            end
            ev = pendingResults.pop_front();
            seen = wbValid ? evWb : (redirectValid ? evRedirect : evIllegal);
            checkValue("pulse count", 32'(wbValid) + 32'(redirectValid) + 32'(illegalValid),
                       32'd1);
            checkValue("result kind", 32'(seen), 32'(ev.kind));
            if (ev.kind == evWb) begin
                checkValue("wbReg", 32'(wbReg), 32'(ev.regNum));
                checkValue("wbData", wbData, ev.value);
            end else if (ev.kind == evRedirect) begin
                checkValue("redirectPc", redirectPc, ev.value);
            end
        end
    end

endmodule

/* list.f */
+incdir+include
hdl/core_pkg.sv
hdl/registerFile.sv
hdl/decodeStage.sv
hdl/idExRegister.sv
hdl/executeStage.sv
hdl/coreTop.sv
sim/coreTop_assert.sv
sim/coreTop_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module coreTop_tb -o coreTop_sim
./obj_dir/coreTop_sim | tee sim.log

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
